// File: verilog/axis_fifo_pkg.sv
// Shared geometry and stream payload type for the packet FIFO.
// Every RTL and testbench file imports this package.

package axis_fifo_pkg;

    ////////////////////
    // FIFO geometry
    ////////////////////

    // Bytes carried by one stream beat
    localparam int data_bytes = 4;

    // Number of words in the distributed RAM
    localparam int fifo_depth = 16;

    // Pointer width, wraps naturally at fifo_depth
    localparam int ptr_w = $clog2(fifo_depth);

    // Headroom left when the full flag rises
    // Covers the one-cycle lag of the registered flag
    localparam int guard_band = 2;

    // Occupancy at which incoming beats start being discarded
    localparam int full_level = fifo_depth - guard_band;

    ////////////////////
    // Types
    ////////////////////

    // One stream beat as stored in RAM and carried on both ports
    // Field order gives data in the upper bits, last in bit 0
    typedef struct packed {
        // Payload bytes
        logic [data_bytes*8-1:0] data;
        // Byte qualifiers, one per data byte
        logic [data_bytes-1:0]   keep;
        // Final beat of a packet
        logic                    last;
    } axis_beat_t;

    // Read and write pointer into the RAM
    typedef logic [ptr_w-1:0] fifo_ptr_t;

endpackage

// File: verilog/fifo_write_ctrl.sv
// Write side of the packet FIFO: stores or discards each input beat
// and reports discarded beats and damaged packets.

`timescale 1ns/1ps

module fifo_write_ctrl import axis_fifo_pkg::*; (
    input  logic       axis_out,
    input  logic       rst_n,

    // Input stream, no ready so the source is never stalled
    input  logic       in_valid,
    input  axis_beat_t in_beat,

    // Read pointer from the read side, for occupancy
    input  fifo_ptr_t  rd_ptr,

    // RAM write port
    output logic       wr_en,
    output fifo_ptr_t  wr_ptr,
    output axis_beat_t wr_beat,

    // Status pulses
    output logic       beat_dropped,
    output logic       pkt_overflow
);

    ////////////////////
    // Declarations
    ////////////////////

    // Words currently held, wr_ptr minus rd_ptr
    fifo_ptr_t occupancy;

    // Guard-band full flag, registered from occupancy
    logic      full;

    // Beat arriving while full is high
    logic      drop_now;

    // Current packet has lost at least one beat
    logic      pkt_lost;

    ////////////////////
    // Store or discard
    ////////////////////

    // Never more than 15 words held, so the 4-bit difference cannot wrap
    assign occupancy = wr_ptr - rd_ptr;

    // Store decision uses the flag from the previous edge
    assign wr_en    = in_valid & ~full;
    assign drop_now = in_valid & full;

    // Payload goes straight to the RAM data port
    assign wr_beat  = in_beat;

    // Write pointer and full flag
    always_ff @(posedge axis_out or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            full   <= 1'b0;
        end else begin
            // Advance only on a stored beat
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // Pointers before this edge's update set the flag
            full <= (occupancy >= fifo_ptr_t'(full_level));
        end
    end

    ////////////////////
    // Loss reporting
    ////////////////////

    // beat_dropped follows every discarded beat by one cycle
    // pkt_overflow marks the last beat of a damaged packet
    always_ff @(posedge axis_out or negedge rst_n) begin
        if (!rst_n) begin
            beat_dropped <= 1'b0;
            pkt_overflow <= 1'b0;
            pkt_lost     <= 1'b0;
        end else begin
            beat_dropped <= drop_now;
            pkt_overflow <= 1'b0;

            if (in_valid && in_beat.last) begin
                // Packet boundary counts even when the last beat itself is dropped
                pkt_overflow <= pkt_lost | drop_now;
                pkt_lost     <= 1'b0;
            end else if (drop_now) begin
                // Remember the loss until the packet ends
                pkt_lost <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/dist_ram_store.sv
// Word storage of the packet FIFO, mapped to LUT RAM.
// Synchronous write port, asynchronous read port.

`timescale 1ns/1ps

module dist_ram_store import axis_fifo_pkg::*; (
    input  logic       axis_out,

    // Write port from the write controller
    input  logic       wr_en,
    input  fifo_ptr_t  wr_ptr,
    input  axis_beat_t wr_beat,

    // Read port to the read controller
    input  fifo_ptr_t  rd_ptr,
    output axis_beat_t rd_beat
);

    ////////////////////
    // Storage array
    ////////////////////

    // One beat per word, contents undefined after reset
    (* ram_style = "distributed" *) axis_beat_t mem [fifo_depth];

    // Write on the clock edge
    always_ff @(posedge axis_out) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    // Read is combinational, as in a LUT RAM
    // Word at rd_ptr is ready for the output register in the same cycle
    assign rd_beat = mem[rd_ptr];

endmodule

// File: verilog/fifo_read_ctrl.sv
// Read side of the packet FIFO: moves beats from RAM into the
// registered AXI-Stream output stage with valid/ready back-pressure.

`timescale 1ns/1ps

module fifo_read_ctrl import axis_fifo_pkg::*; (
    input  logic       axis_out,
    input  logic       rst_n,

    // Write pointer, for empty detection
    input  fifo_ptr_t  wr_ptr,

    // Word at rd_ptr from the RAM
    input  axis_beat_t rd_beat,
    output fifo_ptr_t  rd_ptr,

    // Output stream
    output logic       out_valid,
    output axis_beat_t out_beat,
    input  logic       out_ready
);

    ////////////////////
    // Declarations
    ////////////////////

    // No words waiting in RAM
    logic empty;

    // Downstream takes the current output beat
    logic consume;

    // Output register takes a new word from RAM
    logic load;

    ////////////////////
    // Control
    ////////////////////

    // Pointers equal means nothing stored
    assign empty   = (rd_ptr == wr_ptr);

    assign consume = out_valid & out_ready;

    // Load when data is present and the register is free or emptying now
    assign load    = ~empty & (~out_valid | out_ready);

    // Valid flag and read pointer
    always_ff @(posedge axis_out or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            rd_ptr    <= '0;
        end else begin
            if (load) begin
                out_valid <= 1'b1;
                // Each load frees one RAM word
                rd_ptr    <= rd_ptr + 1'b1;
            end else if (consume) begin
                // Beat taken and nothing to replace it
                out_valid <= 1'b0;
            end
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    // Beat only changes on a load, so it holds while out_ready is low
    always_ff @(posedge axis_out) begin
        if (load) begin
            out_beat <= rd_beat;
        end
    end

endmodule

// File: verilog/axis_dist_ram_fifo.sv
// Single-clock AXI-Stream packet FIFO in distributed RAM.
// Input has no ready; overflowing beats are dropped and reported.

`timescale 1ns/1ps

module axis_dist_ram_fifo import axis_fifo_pkg::*; (
    input  logic       axis_out,
    input  logic       rst_n,

    // Input stream, never back-pressured
    input  logic       in_valid,
    input  axis_beat_t in_beat,

    // Output stream
    output logic       out_valid,
    output axis_beat_t out_beat,
    input  logic       out_ready,

    // Overflow status pulses
    output logic       beat_dropped,
    output logic       pkt_overflow
);

    ////////////////////
    // Internal wires
    ////////////////////

    // RAM write port
    logic       wr_en;
    fifo_ptr_t  wr_ptr;
    axis_beat_t wr_beat;

    // RAM read port
    fifo_ptr_t  rd_ptr;
    axis_beat_t rd_beat;

    ////////////////////
    // Instances
    ////////////////////

    // Store or discard, full flag and loss reporting
    fifo_write_ctrl u_write_ctrl (
        .axis_out     (axis_out),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_beat      (in_beat),
        .rd_ptr       (rd_ptr),
        .wr_en        (wr_en),
        .wr_ptr       (wr_ptr),
        .wr_beat      (wr_beat),
        .beat_dropped (beat_dropped),
        .pkt_overflow (pkt_overflow)
    );

    // LUT RAM holding the beats
    dist_ram_store u_ram (
        .axis_out (axis_out),
        .wr_en    (wr_en),
        .wr_ptr   (wr_ptr),
        .wr_beat  (wr_beat),
        .rd_ptr   (rd_ptr),
        .rd_beat  (rd_beat)
    );

    // Registered output stage
    fifo_read_ctrl u_read_ctrl (
        .axis_out  (axis_out),
        .rst_n     (rst_n),
        .wr_ptr    (wr_ptr),
        .rd_beat   (rd_beat),
        .rd_ptr    (rd_ptr),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

endmodule

// File: tb/axis_fifo_properties.sv
// Concurrent checks on the FIFO output handshake and the overflow pulses.
// Bound into both controllers, each instance ties off the side it cannot see.

`timescale 1ns/1ps

module axis_fifo_properties import axis_fifo_pkg::*; (
    input logic       axis_out,
    input logic       rst_n,
    input logic       out_valid,
    input logic       out_ready,
    input axis_beat_t out_beat,
    input logic       in_valid,
    input logic       beat_dropped,
    input logic       pkt_overflow
);

    // Stalled beat holds until taken
    assert property (@(posedge axis_out) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("Output beat changed while out_ready was low");

    // Register empty in the first cycle out of reset
    assert property (@(posedge axis_out) $rose(rst_n) |-> !out_valid)
        else $error("out_valid high right after reset release");

    // Back-to-back pulses need back-to-back input beats
    assert property (@(posedge axis_out) disable iff (!rst_n)
        beat_dropped && $past(beat_dropped) |-> $past(in_valid) && $past(in_valid, 2))
        else $error("beat_dropped held high without input beats");

    assert property (@(posedge axis_out) disable iff (!rst_n)
        pkt_overflow && $past(pkt_overflow) |-> $past(in_valid) && $past(in_valid, 2))
        else $error("pkt_overflow held high without input beats");

endmodule

bind fifo_read_ctrl axis_fifo_properties u_read_props (
    .axis_out     (axis_out),
    .rst_n        (rst_n),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_beat     (out_beat),
    .in_valid     (1'b0),
    .beat_dropped (1'b0),
    .pkt_overflow (1'b0)
);

bind fifo_write_ctrl axis_fifo_properties u_write_props (
    .axis_out     (axis_out),
    .rst_n        (rst_n),
    .out_valid    (1'b0),
    .out_ready    (1'b1),
    .out_beat     (axis_beat_t'('0)),
    .in_valid     (in_valid),
    .beat_dropped (beat_dropped),
    .pkt_overflow (pkt_overflow)
);

// File: tb/axis_fifo_tb.sv
// Trace-driven testbench for the AXI-Stream packet FIFO.
// Reads tb/axis_fifo_trace.txt from the project root, runs each test in turn and prints a summary.

`timescale 1ns/1ps

module axis_fifo_tb import axis_fifo_pkg::*; ();

    ////////////////////
    // DUT signals
    ////////////////////

    logic       axis_out;
    logic       rst_n;
    logic       in_valid;
    axis_beat_t in_beat;
    logic       out_valid;
    axis_beat_t out_beat;
    logic       out_ready;
    logic       beat_dropped;
    logic       pkt_overflow;

    // Trace contents, one entry per test
    string      t_name[$];
    int         t_mode[$];
    int         t_arg[$];
    int         t_lat[$];
    int         t_drops[$];
    int         t_ovf[$];
    int         t_in_end[$];
    int         t_exp_end[$];

    // Input events, reset length is 0 for a plain beat
    int         ev_rst[$];
    int         ev_gap[$];
    axis_beat_t ev_beat[$];
    axis_beat_t exp_q[$];

    // Monitor results
    axis_beat_t got_q[$];
    int         got_edge_q[$];
    int         in_edge_q[$];
    int         drop_cnt;
    int         ovf_cnt;

    int         cyc = 0;
    int         trace_cycles = 0;
    int         cycle_limit = 0;
    int         seed = 80400;
    int         test_errs;
    int         pass_cnt = 0;
    int         fail_cnt = 0;
    logic       ready_stop;

    axis_dist_ram_fifo dut (
        .axis_out     (axis_out),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_beat      (in_beat),
        .out_valid    (out_valid),
        .out_beat     (out_beat),
        .out_ready    (out_ready),
        .beat_dropped (beat_dropped),
        .pkt_overflow (pkt_overflow)
    );

    // 8 ns clock
    initial begin
        axis_out = 1'b0;
        forever #4 axis_out = ~axis_out;
    end

    // Counts rising edges since time zero
    always @(posedge axis_out) cyc <= cyc + 1;

    // Timeout from the trace length
    initial begin
        wait (cycle_limit > 0);
        wait (cyc >= cycle_limit);
        $display("Timeout: tests still running after %0d clock cycles", cycle_limit);
        $display("sim failed");
        $finish;
    end

    ////////////////////
    // Monitor
    ////////////////////

    // Mid-cycle sampling, all signals settled
    // Output edge is the edge after which the beat became visible
    // Input edge is the edge that samples the beat
    always @(negedge axis_out) begin
        if (out_valid && out_ready) begin
            got_q.push_back(out_beat);
            got_edge_q.push_back(cyc);
        end
        if (in_valid) begin
            in_edge_q.push_back(cyc + 1);
        end
        if (beat_dropped) drop_cnt++;
        if (pkt_overflow) ovf_cnt++;
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_beat(string name, int idx, axis_beat_t exp, axis_beat_t act);
        if (act !== exp) begin
            $display("ERROR %s beat %0d: expected %h/%h/%b, actual %h/%h/%b",
                     name, idx, exp.data, exp.keep, exp.last, act.data, act.keep, act.last);
            test_errs++;
        end
    endtask

    task automatic check_count(string name, string what, integer exp, integer act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %0d, actual %0d", name, what, exp, act);
            test_errs++;
        end
    endtask

    ////////////////////
    // Trace reading
    ////////////////////

    // Beat idx of an n-beat packet, data counts up from base
    // Final beat of a complete packet carries its own keep and last
    function automatic axis_beat_t make_beat(int base, int idx, int n, int last_keep, int last);
        axis_beat_t b;
        b.data = base + idx;
        b.keep = '1;
        b.last = 1'b0;
        if (last != 0 && idx == n - 1) begin
            b.keep = last_keep[data_bytes-1:0];
            b.last = 1'b1;
        end
        return b;
    endfunction

    task automatic load_trace(output bit ok);
        int    fd;
        int    n;
        int    i;
        int    a, b, c, d, e;
        string line;
        string key;
        string name;
        fd = $fopen("tb/axis_fifo_trace.txt", "r");
        ok = (fd != 0);
        while (ok && !$feof(fd)) begin
            line = "";
            key  = "";
            n    = $fgets(line, fd);
            n    = $sscanf(line, "%s", key);
            if (n < 1 || key.len() == 0 || key[0] == "#") continue;
            if (key == "test") begin
                n = $sscanf(line, "%s %s %d %d %d", key, name, a, b, c);
                t_name.push_back(name);
                t_mode.push_back(a);
                t_arg.push_back(b);
                t_lat.push_back(c);
                if (a == 2) trace_cycles += b;
            end else if (key == "pkt") begin
                n = $sscanf(line, "%s %d %d %h %h %d", key, a, b, c, d, e);
                for (i = 0; i < b; i++) begin
                    ev_rst.push_back(0);
                    ev_gap.push_back(a);
                    ev_beat.push_back(make_beat(c, i, b, d, e));
                end
                trace_cycles += b * (a + 1);
            end else if (key == "rst") begin
                n = $sscanf(line, "%s %d", key, a);
                ev_rst.push_back(a);
                ev_gap.push_back(0);
                ev_beat.push_back(axis_beat_t'('0));
                trace_cycles += a;
            end else if (key == "exp") begin
                n = $sscanf(line, "%s %d %h %h %d", key, a, b, c, d);
                for (i = 0; i < a; i++) exp_q.push_back(make_beat(b, i, a, c, d));
            end else if (key == "end") begin
                n = $sscanf(line, "%s %d %d", key, a, b);
                t_drops.push_back(a);
                t_ovf.push_back(b);
                t_in_end.push_back(ev_rst.size());
                t_exp_end.push_back(exp_q.size());
            end
        end
        if (ok) $fclose(fd);
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic drive_inputs(string name, int first, int stop);
        int i;
        for (i = first; i < stop; i++) begin
            if (ev_rst[i] > 0) begin
                // Asynchronous reset in the middle of the stream
                @(posedge axis_out);
                #1;
                in_valid = 1'b0;
                rst_n    = 1'b0;
                repeat (ev_rst[i]) @(posedge axis_out);
                #1;
                rst_n = 1'b1;
                check_count(name, "out_valid after reset", 0, out_valid);
                check_count(name, "beat_dropped after reset", 0, beat_dropped);
                check_count(name, "pkt_overflow after reset", 0, pkt_overflow);
            end else begin
                repeat (ev_gap[i]) begin
                    @(posedge axis_out);
                    #1;
                    in_valid = 1'b0;
                end
                @(posedge axis_out);
                #1;
                in_valid = 1'b1;
                in_beat  = ev_beat[i];
            end
        end
        @(posedge axis_out);
        #1;
        in_valid = 1'b0;
    endtask

    // Mode 0 always ready, 1 random, 2 low for arg cycles then high
    task automatic drive_ready(int mode, int arg);
        if (mode == 1) begin
            while (!ready_stop) begin
                out_ready = ($random(seed) & 1) != 0;
                @(posedge axis_out);
                #1;
            end
        end else if (mode == 2) begin
            out_ready = 1'b0;
            repeat (arg) @(posedge axis_out);
            #1;
        end
        out_ready = 1'b1;
    endtask

    task automatic run_test(int t, int in_first, int exp_first);
        string name;
        int    exp_n;
        int    n_cmp;
        int    idle;
        int    i;
        name       = t_name[t];
        exp_n      = t_exp_end[t] - exp_first;
        test_errs  = 0;
        ready_stop = 1'b0;
        @(posedge axis_out);
        #1;
        got_q.delete();
        got_edge_q.delete();
        in_edge_q.delete();
        drop_cnt = 0;
        ovf_cnt  = 0;
        fork
            begin
                drive_inputs(name, in_first, t_in_end[t]);
                // Two idle output cycles with no input left means the FIFO is drained
                idle = 0;
                while (idle < 2) begin
                    @(negedge axis_out);
                    if (out_valid) idle = 0;
                    else idle++;
                end
                ready_stop = 1'b1;
            end
            drive_ready(t_mode[t], t_arg[t]);
        join
        @(posedge axis_out);
        #1;
        check_count(name, "output beat count", exp_n, got_q.size());
        n_cmp = (got_q.size() < exp_n) ? got_q.size() : exp_n;
        for (i = 0; i < n_cmp; i++) check_beat(name, i, exp_q[exp_first + i], got_q[i]);
        check_count(name, "beat_dropped pulses", t_drops[t], drop_cnt);
        check_count(name, "pkt_overflow pulses", t_ovf[t], ovf_cnt);
        // Stored at edge k, visible right after edge k+1
        if (t_lat[t] != 0) begin
            check_count(name, "sampled input beats", exp_n, in_edge_q.size());
            for (i = 0; i < n_cmp && i < in_edge_q.size(); i++) begin
                check_count(name, $sformatf("latency of beat %0d", i), 1,
                            got_edge_q[i] - in_edge_q[i]);
            end
        end
        if (test_errs == 0) begin
            pass_cnt++;
            $display("Test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("Test %s: %0d errors", name, test_errs);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        bit ok;
        int t;
        int in_pos;
        int exp_pos;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_beat   = '0;
        out_ready = 1'b0;
        load_trace(ok);
        if (!ok) begin
            $display("Trace file tb/axis_fifo_trace.txt could not be opened");
            $display("sim failed");
            $finish;
        end else begin
            cycle_limit = trace_cycles * 4 + 200;
            repeat (8) @(posedge axis_out);
            #1;
            rst_n   = 1'b1;
            in_pos  = 0;
            exp_pos = 0;
            for (t = 0; t < t_name.size(); t++) begin
                run_test(t, in_pos, exp_pos);
                in_pos  = t_in_end[t];
                exp_pos = t_exp_end[t];
            end
            $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
            if (fail_cnt == 0 && pass_cnt > 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

// File: tb/axis_fifo_trace.txt
# test <name> <ready: 0 high, 1 random, 2 low for N cycles> <N> <latency check 0/1>
# pkt <idle cycles before each beat> <beats> <first data hex> <keep of last beat hex> <last set>
# rst <cycles> | exp <beats> <first data hex> <keep of last beat hex> <last set> | end <drops> <overflows>

# Single packet, ready always high
test single_packet 0 0 0
pkt 0 5 a0000000 7 1
exp 5 a0000000 7 1
end 0 0

# Back-to-back beats, each visible one cycle after it is stored
test streaming_latency 0 0 1
pkt 0 8 b0000000 3 1
exp 8 b0000000 3 1
end 0 0

# Random ready, input at one beat in four keeps occupancy well below 14
test random_backpressure 1 0 0
pkt 3 1 c0000000 1 1
pkt 3 12 c0000100 f 1
pkt 3 4 c0000200 3 1
pkt 3 7 c0000300 7 1
exp 1 c0000000 1 1
exp 12 c0000100 f 1
exp 4 c0000200 3 1
exp 7 c0000300 7 1
end 0 0

# Ready low for 30 cycles, 20 beats without gaps
# 1 beat in the output register plus 15 in RAM, the other 4 dropped
test overflow 2 30 0
pkt 0 20 d0000000 f 1
exp 16 d0000000 f 0
end 4 1

# Clean packet after the overflow
test recovery 0 0 0
pkt 1 6 e0000000 1 1
exp 6 e0000000 1 1
end 0 0

# Partial packet flushed by reset, only the later packet comes out
test mid_stream_reset 2 16 0
pkt 0 3 f0000000 f 0
rst 4
pkt 0 2 f0000100 c 1
exp 2 f0000100 c 1
end 0 0

// File: all.f
verilog/axis_fifo_pkg.sv
verilog/fifo_write_ctrl.sv
verilog/dist_ram_store.sv
verilog/fifo_read_ctrl.sv
verilog/axis_dist_ram_fifo.sv
tb/axis_fifo_properties.sv
tb/axis_fifo_tb.sv

// File: Bender.yml
package:
  name: axis_dist_ram_fifo

sources:
  # RTL in compile order
  - files:
      - verilog/axis_fifo_pkg.sv
      - verilog/fifo_write_ctrl.sv
      - verilog/dist_ram_store.sv
      - verilog/fifo_read_ctrl.sv
      - verilog/axis_dist_ram_fifo.sv
  # Testbench and bound assertions
  - target: test
    files:
      - tb/axis_fifo_properties.sv
      - tb/axis_fifo_tb.sv
